/* sim.f */
hw/life_pkg.sv
hw/uart_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/lfsr_rng.sv
hw/life_control.sv
hw/life_board.sv
hw/terminal_display.sv
hw/life_top.sv
verification/life_tb.sv

/* Makefile */
TOP = life_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f sim.f -o $(TOP)_sim

run: compile
	./obj_dir/$(TOP)_sim > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/life_tb.sv */
`timescale 1ns/1ps

module life_tb;

  localparam int BIT_CYCLES = uart_pkg::CLKS_PER_BIT;
  localparam int BYTE_CYCLES = 10 * BIT_CYCLES + 8; // 8N1 bits plus handshake gap
  localparam int FRAME_BYTES = 84;
  localparam int FRAME_CYCLES = FRAME_BYTES * BYTE_CYCLES;
  localparam int INTERVAL_CYCLES = int'(life_pkg::UPDATE_INTERVAL);
  localparam int RESPONSE_CYCLES = 2000; // Update, copy and first byte of a frame
  localparam int WATCHDOG_CYCLES = 20 * FRAME_CYCLES + 10 * INTERVAL_CYCLES;
  localparam logic [31:0] RANDOM_SEED = 32'hf6df_b5e4;
  localparam logic [7:0] UNKNOWN_CMD = 8'h78; // 'x'
  localparam int ROWS = life_pkg::HEIGHT;
  localparam int COLS = life_pkg::WIDTH;

  logic clk;
  logic boot_reset;
  logic rx;
  logic tx;

  bit frame_board [ROWS][COLS]; // Last board printed by the DUT
  bit model_board [ROWS][COLS];

  life_top i_life_top (.clk(clk), .boot_reset(boot_reset), .rx(rx), .tx(tx));

  always #4 clk = ~clk;

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                              $time, name, actual, expected));
    end
  endtask

  // 8N1 with LSB first and one bit every BIT_CYCLES clocks
  task automatic send_byte(input logic [7:0] data);
    logic [9:0] line_bits;
    line_bits = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= line_bits[i];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
  endtask

  task automatic wait_start_bit(input int max_cycles, output bit found);
    int count;
    found = 1'b0;
    count = 0;
    while (!found && count < max_cycles) begin
      @(negedge clk);
      if (tx === 1'b0) found = 1'b1;
      count++;
    end
  endtask

  task automatic receive_byte(input int max_cycles, output logic [7:0] data);
    bit found;
    wait_start_bit(max_cycles, found);
    if (!found) begin
      stop_on_error($sformatf("No byte arrived on tx within %0d cycles", max_cycles));
    end else begin
      repeat (BIT_CYCLES / 2) @(negedge clk); // Middle of the start bit
      check_value("tx start bit", {7'd0, tx}, 8'h00);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        data[i] = tx;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      check_value("tx stop bit", {7'd0, tx}, 8'h01);
    end
  endtask

  // Home sequence then rows of cells each closed by CR LF
  task automatic read_frame(input int first_timeout);
    logic [7:0] data;
    logic [7:0] home_seq [4];
    int timeout;
    home_seq = '{uart_pkg::CHAR_ESC, uart_pkg::CHAR_LBRACKET, uart_pkg::CHAR_SEMI,
                 uart_pkg::CHAR_HOME_H};
    timeout = first_timeout;
    for (int k = 0; k < 4; k++) begin
      receive_byte(timeout, data);
      timeout = 2 * BYTE_CYCLES;
      check_value($sformatf("home byte %0d", k), data, home_seq[k]);
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        receive_byte(timeout, data);
        if (data == life_pkg::CELL_ALIVE_CHAR) begin
          frame_board[r][c] = 1'b1;
        end else begin
          check_value($sformatf("cell char row %0d col %0d", r, c), data,
                      life_pkg::CELL_DEAD_CHAR);
          frame_board[r][c] = 1'b0;
        end
      end
      receive_byte(timeout, data);
      check_value($sformatf("CR after row %0d", r), data, uart_pkg::CHAR_CR);
      receive_byte(timeout, data);
      check_value($sformatf("LF after row %0d", r), data, uart_pkg::CHAR_LF);
    end
  endtask

  // Next generation of frame_board on a torus
  task automatic compute_next_generation();
    int count;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        count = 0;
        for (int dr = -1; dr <= 1; dr++) begin
          for (int dc = -1; dc <= 1; dc++) begin
            if ((dr != 0 || dc != 0) &&
                frame_board[(r + dr + ROWS) % ROWS][(c + dc + COLS) % COLS])
              count++;
          end
        end
        model_board[r][c] = (count == 3) || (frame_board[r][c] && count == 2);
      end
    end
  endtask

  task automatic check_board_against_model();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        check_value($sformatf("cell row %0d col %0d", r, c), {7'd0, frame_board[r][c]},
                    {7'd0, model_board[r][c]});
      end
    end
  endtask

  task automatic start_game_frame();
    logic [7:0] first_byte;
    first_byte = 8'($urandom());
    send_byte(first_byte);
    read_frame(RESPONSE_CYCLES);
  endtask

  task automatic step_three_times();
    repeat (3) begin
      compute_next_generation();
      send_byte(life_pkg::CMD_STEP);
      read_frame(RESPONSE_CYCLES);
      check_board_against_model();
    end
  endtask

  task automatic randomize_then_step();
    send_byte(life_pkg::CMD_RANDOMIZE);
    read_frame(RESPONSE_CYCLES);
    compute_next_generation();
    send_byte(life_pkg::CMD_STEP);
    read_frame(RESPONSE_CYCLES);
    check_board_against_model();
  endtask

  task automatic ignore_unknown_byte();
    bit found;
    send_byte(UNKNOWN_CMD);
    wait_start_bit(2 * FRAME_CYCLES, found);
    if (found) stop_on_error("Output appeared on tx after an unknown command byte");
  endtask

  task automatic run_then_stop();
    bit found;
    compute_next_generation();
    send_byte(life_pkg::CMD_RUN_TOGGLE);
    read_frame(INTERVAL_CYCLES + RESPONSE_CYCLES); // Timer expiry starts the update
    check_board_against_model();
    send_byte(life_pkg::CMD_STEP);
    wait_start_bit(3 * INTERVAL_CYCLES, found);
    if (found) stop_on_error("A frame arrived after the step key stopped run mode");
  endtask

  initial begin
    clk = 1'b0;
    boot_reset <= 1'b1;
    rx <= 1'b1; // Serial line idles high
    void'($urandom(RANDOM_SEED));
    repeat (8) @(posedge clk);
    boot_reset <= 1'b0;
    repeat (4) @(posedge clk);
    start_game_frame();
    step_three_times();
    randomize_then_step();
    ignore_unknown_byte();
    run_then_stop();
    $display("Test completed successfully");
    $finish;
  end

  // Watchdog sized from frame times and update intervals
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_error($sformatf("Timeout: tests did not finish within %0d cycles",
                            WATCHDOG_CYCLES));
  end

endmodule

/* hw/life_top.sv */
`timescale 1ns/1ps

module life_top (
  input  logic clk,
  input  logic boot_reset,
  input  logic rx,
  output logic tx
);

  logic [7:0]            rx_data;
  logic                  rx_valid;
  logic                  rx_ready;
  logic [7:0]            tx_data;
  logic                  tx_valid;
  logic                  tx_ready;
  life_pkg::action_t     action;
  logic                  rnd_done;
  logic                  update_done;
  logic                  copy_done;
  logic                  display_done;
  life_pkg::cell_index_t read_index;
  logic                  read_cell;
  logic                  random_bit;

  uart_rx i_uart_rx (
    .clk(clk), .boot_reset(boot_reset), .rx(rx),
    .rx_ready(rx_ready), .rx_data(rx_data), .rx_valid(rx_valid)
  );

  uart_tx i_uart_tx (
    .clk(clk), .boot_reset(boot_reset), .tx_data(tx_data),
    .tx_valid(tx_valid), .tx(tx), .tx_ready(tx_ready)
  );

  lfsr_rng i_lfsr_rng (.clk(clk), .boot_reset(boot_reset), .random_bit(random_bit));

  life_control i_life_control (
    .clk(clk), .boot_reset(boot_reset), .rx_data(rx_data), .rx_valid(rx_valid),
    .rx_ready(rx_ready), .rnd_done(rnd_done), .update_done(update_done),
    .copy_done(copy_done), .display_done(display_done), .action(action)
  );

  life_board i_life_board (
    .clk(clk), .boot_reset(boot_reset), .action(action), .random_bit(random_bit),
    .read_index(read_index), .read_cell(read_cell), .rnd_done(rnd_done),
    .update_done(update_done), .copy_done(copy_done)
  );

  // Frames go out over the serial line after every board change
  terminal_display i_terminal_display (
    .clk(clk), .boot_reset(boot_reset), .action(action), .read_index(read_index),
    .read_cell(read_cell), .tx_ready(tx_ready), .tx_data(tx_data),
    .tx_valid(tx_valid), .display_done(display_done)
  );

endmodule

/* hw/terminal_display.sv */
`timescale 1ns/1ps

module terminal_display (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  life_pkg::action_t     action,
  output life_pkg::cell_index_t read_index,
  input  logic                  read_cell,
  input  logic                  tx_ready,
  output logic [7:0]            tx_data,
  output logic                  tx_valid,
  output logic                  display_done
);

  life_pkg::display_state_t state;
  logic [1:0]               char_index; // Position in home or CR LF sequence
  logic                     waiting;
  logic                     byte_sent;

  assign waiting = (state == life_pkg::disp_wait_home) || (state == life_pkg::disp_wait_cell) ||
                   (state == life_pkg::disp_wait_crlf);
  assign byte_sent = tx_valid && !tx_ready; // Transmitter took the byte

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= life_pkg::disp_idle;
      read_index <= '0;
      char_index <= '0;
      tx_valid <= 1'b0;
      display_done <= 1'b0;
    end else if (action == life_pkg::action_display && !display_done) begin
      if (waiting && tx_ready && !tx_valid) tx_valid <= 1'b1;
      if (byte_sent) tx_valid <= 1'b0;
      case (state)
        life_pkg::disp_idle: begin
          read_index <= '0;
          char_index <= '0;
          state <= life_pkg::disp_home;
        end
        life_pkg::disp_home: begin
          case (char_index)
            2'd0: tx_data <= uart_pkg::CHAR_ESC;
            2'd1: tx_data <= uart_pkg::CHAR_LBRACKET;
            2'd2: tx_data <= uart_pkg::CHAR_SEMI;
            default: tx_data <= uart_pkg::CHAR_HOME_H;
          endcase
          state <= life_pkg::disp_wait_home;
        end
        life_pkg::disp_wait_home: begin
          if (byte_sent) begin
            char_index <= char_index + 2'd1; // Wraps to 0 after H
            state <= (char_index == 2'd3) ? life_pkg::disp_cell : life_pkg::disp_home;
          end
        end
        life_pkg::disp_cell: begin
          tx_data <= read_cell ? life_pkg::CELL_ALIVE_CHAR : life_pkg::CELL_DEAD_CHAR;
          state <= life_pkg::disp_wait_cell;
        end
        life_pkg::disp_wait_cell: begin
          if (byte_sent) begin
            read_index <= read_index + life_pkg::cell_index_t'(1);
            // Column bits all ones means the row is finished
            if (&read_index[life_pkg::LOG_WIDTH-1:0]) state <= life_pkg::disp_crlf;
            else state <= life_pkg::disp_cell;
          end
        end
        life_pkg::disp_crlf: begin
          tx_data <= char_index[0] ? uart_pkg::CHAR_LF : uart_pkg::CHAR_CR;
          state <= life_pkg::disp_wait_crlf;
        end
        default: begin
          if (byte_sent) begin
            if (char_index[0]) begin
              char_index <= '0;
              if (read_index == '0) begin // Index wrapped after the last row
                display_done <= 1'b1;
                state <= life_pkg::disp_idle;
              end else begin
                state <= life_pkg::disp_cell;
              end
            end else begin
              char_index <= char_index + 2'd1;
              state <= life_pkg::disp_crlf;
            end
          end
        end
      endcase
    end else begin
      display_done <= 1'b0;
    end
  end

endmodule

/* hw/life_board.sv */
`timescale 1ns/1ps

module life_board (
  input  logic                  clk,
  input  logic                  boot_reset,
  input  life_pkg::action_t     action,
  input  logic                  random_bit,
  input  life_pkg::cell_index_t read_index,
  output logic                  read_cell,
  output logic                  rnd_done,
  output logic                  update_done,
  output logic                  copy_done
);

  logic [life_pkg::BOARD_SIZE-1:0] board_state; // Current generation
  logic [life_pkg::BOARD_SIZE-1:0] board_next;

  // Randomize and copy share one sweep over all cells
  life_pkg::cell_index_t sweep_index;
  logic                  sweep_done;
  logic                  sweep_active;

  life_pkg::cell_index_t         update_index;
  logic [3:0]                    neigh_index; // Neighbours 0 to 7 and the rule step at 8
  logic [3:0]                    num_neighbors;
  logic                          update_active;
  logic [life_pkg::LOG_WIDTH-1:0]  cell_x;
  logic [life_pkg::LOG_HEIGHT-1:0] cell_y;
  logic [life_pkg::LOG_WIDTH-1:0]  neigh_x;
  logic [life_pkg::LOG_HEIGHT-1:0] neigh_y;

  assign read_cell = board_state[read_index];

  assign sweep_active = (action == life_pkg::action_rnd || action == life_pkg::action_copy)
                        && !sweep_done;
  assign rnd_done = sweep_done && (action == life_pkg::action_rnd);
  assign copy_done = sweep_done && (action == life_pkg::action_copy);

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      sweep_index <= '0;
      sweep_done <= 1'b0;
    end else if (sweep_active) begin
      sweep_index <= sweep_index + life_pkg::cell_index_t'(1); // Wraps to 0 after last cell
      if (sweep_index == life_pkg::LAST_CELL) sweep_done <= 1'b1;
    end else begin
      sweep_done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_active && action == life_pkg::action_rnd) board_state[sweep_index] <= random_bit;
    else if (sweep_active) board_state[sweep_index] <= board_next[sweep_index];
  end

  assign update_active = (action == life_pkg::action_update) && !update_done;
  assign cell_x = update_index[life_pkg::LOG_WIDTH-1:0];
  assign cell_y = update_index[life_pkg::LOG_WIDTH +: life_pkg::LOG_HEIGHT];

  // Neighbour offsets wrap at the edges
  always_comb begin
    case (neigh_index)
      4'd0, 4'd1, 4'd2: neigh_y = cell_y - 3'd1;
      4'd3, 4'd4: neigh_y = cell_y;
      default: neigh_y = cell_y + 3'd1;
    endcase
    case (neigh_index)
      4'd0, 4'd3, 4'd5: neigh_x = cell_x - 3'd1;
      4'd1, 4'd6: neigh_x = cell_x;
      default: neigh_x = cell_x + 3'd1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      update_index <= '0;
      neigh_index <= '0;
      num_neighbors <= '0;
      update_done <= 1'b0;
    end else if (update_active) begin
      if (neigh_index == 4'd8) begin
        neigh_index <= '0;
        num_neighbors <= '0;
        update_index <= update_index + life_pkg::cell_index_t'(1);
        if (update_index == life_pkg::LAST_CELL) update_done <= 1'b1;
      end else begin
        num_neighbors <= num_neighbors + {3'b000, board_state[{neigh_y, neigh_x}]};
        neigh_index <= neigh_index + 4'd1;
      end
    end else begin
      update_done <= 1'b0;
    end
  end

  // Birth on 3 and survival on 2 or 3
  always_ff @(posedge clk) begin
    if (update_active && neigh_index == 4'd8)
      board_next[update_index] <= (num_neighbors == 4'd3) ||
                                  (board_state[update_index] && num_neighbors == 4'd2);
  end

endmodule

/* hw/life_control.sv */
`timescale 1ns/1ps

module life_control (
  input  logic              clk,
  input  logic              boot_reset,
  input  logic [7:0]        rx_data,
  input  logic              rx_valid,
  output logic              rx_ready,
  input  logic              rnd_done,
  input  logic              update_done,
  input  logic              copy_done,
  input  logic              display_done,
  output life_pkg::action_t action
);

  logic        running; // Automatic stepping on
  logic [31:0] timer;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      action <= life_pkg::action_init;
      running <= 1'b0;
      timer <= '0;
      rx_ready <= 1'b0;
    end else begin
      case (action)
        // First byte of any value starts the game
        life_pkg::action_init: begin
          if (rx_valid && rx_ready) begin
            rx_ready <= 1'b0;
            action <= life_pkg::action_rnd;
          end else if (rx_valid) begin
            rx_ready <= 1'b1;
          end
        end
        life_pkg::action_idle: begin
          if (rx_valid && rx_ready) begin
            rx_ready <= 1'b0;
            case (rx_data)
              life_pkg::CMD_RANDOMIZE: action <= life_pkg::action_rnd;
              life_pkg::CMD_STEP: begin
                if (!running) begin
                  action <= life_pkg::action_update;
                end else begin
                  running <= 1'b0; // Step key also halts run mode
                  timer <= '0;
                end
              end
              life_pkg::CMD_RUN_TOGGLE: begin
                running <= !running;
                timer <= '0;
              end
              default: ; // Unknown bytes ignored
            endcase
          end else if (rx_valid) begin
            rx_ready <= 1'b1;
          end else if (running) begin
            if (timer < life_pkg::UPDATE_INTERVAL) begin
              timer <= timer + 32'd1;
            end else begin
              timer <= '0;
              action <= life_pkg::action_update;
            end
          end
        end
        life_pkg::action_rnd: if (rnd_done) action <= life_pkg::action_display;
        life_pkg::action_update: if (update_done) action <= life_pkg::action_copy;
        life_pkg::action_copy: if (copy_done) action <= life_pkg::action_display;
        life_pkg::action_display: if (display_done) action <= life_pkg::action_idle;
        default: action <= life_pkg::action_idle;
      endcase
    end
  end

endmodule

/* hw/lfsr_rng.sv */
`timescale 1ns/1ps

module lfsr_rng (
  input  logic clk,
  input  logic boot_reset,
  output logic random_bit
);

  logic [15:0] lfsr;
  logic        feedback;

  // Taps 16, 14, 13, 11 give the maximal period
  assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
  assign random_bit = lfsr[0];

  always_ff @(posedge clk) begin
    if (boot_reset) lfsr <= 16'hace1; // Any nonzero seed
    else lfsr <= {lfsr[14:0], feedback};
  end

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
  input  logic       clk,
  input  logic       boot_reset,
  input  logic [7:0] tx_data,
  input  logic       tx_valid,
  output logic       tx,
  output logic       tx_ready
);

  typedef enum logic [1:0] {tx_idle, tx_start, tx_data_bits, tx_stop} tx_state_t;

  tx_state_t            state;
  uart_pkg::bit_count_t clk_count;
  logic [2:0]           bit_index;
  logic [7:0]           shift_reg;

  assign tx_ready = (state == tx_idle);

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      state <= tx_idle;
      tx <= 1'b1;
      clk_count <= '0;
      bit_index <= '0;
    end else begin
      if (state != tx_idle) clk_count <= clk_count + uart_pkg::bit_count_t'(1);
      case (state)
        tx_idle: begin
          tx <= 1'b1;
          clk_count <= '0;
          if (tx_valid) begin
            shift_reg <= tx_data;
            tx <= 1'b0; // Start bit
            state <= tx_start;
          end
        end
        tx_start: begin
          if (clk_count == uart_pkg::BIT_LAST) begin
            tx <= shift_reg[0];
            shift_reg <= shift_reg >> 1;
            bit_index <= '0;
            state <= tx_data_bits;
          end
        end
        tx_data_bits: begin
          if (clk_count == uart_pkg::BIT_LAST) begin
            if (bit_index == 3'd7) begin
              tx <= 1'b1; // Stop bit
              state <= tx_stop;
            end else begin
              tx <= shift_reg[0];
              shift_reg <= shift_reg >> 1;
              bit_index <= bit_index + 3'd1;
            end
          end
        end
        default: begin
          if (clk_count == uart_pkg::BIT_LAST) state <= tx_idle;
        end
      endcase
    end
  end

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       boot_reset,
  input  logic       rx,
  input  logic       rx_ready,
  output logic [7:0] rx_data,
  output logic       rx_valid
);

  typedef enum logic [1:0] {rx_idle, rx_start, rx_data_bits, rx_stop} rx_state_t;

  rx_state_t            state;
  logic                 rx_meta;
  logic                 rx_sync;
  uart_pkg::bit_count_t clk_count;
  logic [2:0]           bit_index;
  logic [7:0]           shift_reg;

  always_ff @(posedge clk) begin
    if (boot_reset) begin
      rx_meta <= 1'b1; // Line idles high
      rx_sync <= 1'b1;
      state <= rx_idle;
      clk_count <= '0;
      bit_index <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      if (rx_valid && rx_ready) rx_valid <= 1'b0; // Byte consumed
      case (state)
        rx_idle: begin
          clk_count <= '0;
          if (!rx_sync) state <= rx_start;
        end
        // Confirm the start bit at its middle
        rx_start: begin
          if (clk_count == uart_pkg::HALF_BIT_LAST) begin
            clk_count <= '0;
            bit_index <= '0;
            state <= rx_sync ? rx_idle : rx_data_bits;
          end else begin
            clk_count <= clk_count + uart_pkg::bit_count_t'(1);
          end
        end
        rx_data_bits: begin
          if (clk_count == uart_pkg::BIT_LAST) begin
            clk_count <= '0;
            shift_reg <= {rx_sync, shift_reg[7:1]}; // LSB arrives first
            if (bit_index == 3'd7) state <= rx_stop;
            else bit_index <= bit_index + 3'd1;
          end else begin
            clk_count <= clk_count + uart_pkg::bit_count_t'(1);
          end
        end
        default: begin
          if (clk_count == uart_pkg::BIT_LAST) begin
            state <= rx_idle;
            // Bad stop bit or unconsumed previous byte drops this one
            if (rx_sync && !rx_valid) begin
              rx_data <= shift_reg;
              rx_valid <= 1'b1;
            end
          end else begin
            clk_count <= clk_count + uart_pkg::bit_count_t'(1);
          end
        end
      endcase
    end
  end

endmodule

/* hw/uart_pkg.sv */
package uart_pkg;

  localparam int CLKS_PER_BIT = 16; // Short bit time for fast simulation
  localparam int BIT_CNT_WIDTH = $clog2(CLKS_PER_BIT);

  typedef logic [BIT_CNT_WIDTH-1:0] bit_count_t;
  localparam bit_count_t BIT_LAST = bit_count_t'(CLKS_PER_BIT - 1);
  localparam bit_count_t HALF_BIT_LAST = bit_count_t'(CLKS_PER_BIT / 2 - 1);

  // ANSI cursor home is ESC [ ; H
  localparam logic [7:0] CHAR_ESC = 8'h1b;
  localparam logic [7:0] CHAR_LBRACKET = 8'h5b;
  localparam logic [7:0] CHAR_SEMI = 8'h3b;
  localparam logic [7:0] CHAR_HOME_H = 8'h48;
  localparam logic [7:0] CHAR_CR = 8'h0d;
  localparam logic [7:0] CHAR_LF = 8'h0a;

endpackage

/* hw/life_pkg.sv */
package life_pkg;

  // Board geometry of an 8x8 torus
  localparam int LOG_WIDTH = 3;
  localparam int LOG_HEIGHT = 3;
  localparam int WIDTH = 2 ** LOG_WIDTH;
  localparam int HEIGHT = 2 ** LOG_HEIGHT;
  localparam int BOARD_SIZE = WIDTH * HEIGHT;

  typedef logic [LOG_WIDTH+LOG_HEIGHT-1:0] cell_index_t; // Row in upper bits and column in lower
  localparam cell_index_t LAST_CELL = cell_index_t'(BOARD_SIZE - 1);

  typedef enum logic [2:0] {
    action_init, action_idle, action_rnd, action_update, action_copy, action_display
  } action_t;

  typedef enum logic [2:0] {
    disp_idle, disp_home, disp_wait_home, disp_cell, disp_wait_cell, disp_crlf, disp_wait_crlf
  } display_state_t;

  localparam logic [7:0] CMD_RANDOMIZE = 8'h30;  // '0'
  localparam logic [7:0] CMD_STEP = 8'h31;       // '1'
  localparam logic [7:0] CMD_RUN_TOGGLE = 8'h20; // Space
  localparam logic [7:0] CELL_ALIVE_CHAR = 8'h4f; // 'O'
  localparam logic [7:0] CELL_DEAD_CHAR = 8'h20;

  localparam logic [31:0] UPDATE_INTERVAL = 32'd20000; // Cycles between automatic steps

endpackage
